// File: hdl/sync_fifo_pkg.sv
// shared defaults and flag bundles for the sync FIFO controller, used by scoped name
`default_nettype none

package sync_fifo_pkg;

   // --------------------------------------------------
   // default parameter values
   // --------------------------------------------------

   // depth is 2**ADDR_W entries
   parameter int DEF_ADDR_W       = 4;

   // almost full asserts near this occupancy
   parameter int DEF_AFULL_LEVEL  = 12;

   // almost empty asserts at or below this occupancy
   parameter int DEF_AEMPTY_LEVEL = 4;

   // --------------------------------------------------
   // flag bundles
   // --------------------------------------------------

   // write side status, all registered
   typedef struct packed {
      logic full;       // no room, writes refused
      logic afull;      // hysteretic almost full
      logic wack;       // write accepted last cycle
      logic overflow;   // write refused last cycle
   } wr_flags_t;

   // read side status, all registered
   typedef struct packed {
      logic empty;      // nothing stored, reads refused
      logic aempty;     // hysteretic almost empty
      logic dvld;       // read accepted last cycle
      logic underflow;  // read refused last cycle
   } rd_flags_t;

endpackage

`default_nettype wire

// File: hdl/fifo_write_port.sv
// write side of the FIFO controller: write pointer, memory write address and full status
`default_nettype none
`timescale 1ns/1ps

module fifo_write_port #(
   parameter int ADDR_W      = sync_fifo_pkg::DEF_ADDR_W,
   parameter int AFULL_LEVEL = sync_fifo_pkg::DEF_AFULL_LEVEL
) (
   input  wire                       pos_clk,
   input  wire                       aresetn,
   input  wire                       we_i,
   input  wire  [ADDR_W:0]           rptr_i,
   output logic [ADDR_W:0]           wptr_o,
   output sync_fifo_pkg::wr_flags_t  wr_flags_o,
   output logic [ADDR_W:0]           wrcnt_o,
   output logic [ADDR_W-1:0]         memwaddr_o,
   output logic                      memwe_o
);

   // --------------------------------------------------
   // constants
   // --------------------------------------------------

   // pointer carries one extra wrap bit
   localparam int PTR_W = ADDR_W + 1;
   localparam int DEPTH = 2 ** ADDR_W;

   // full once occupancy reaches the depth
   localparam logic [PTR_W-1:0] FULL_THR = PTR_W'(DEPTH);
   // almost full compares one below the level
   localparam logic [PTR_W-1:0] AF_THR = PTR_W'(AFULL_LEVEL - 1);
   // last memory address before wrap
   localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

   // --------------------------------------------------
   // state and next-state signals
   // --------------------------------------------------
   logic [PTR_W-1:0]          wptr_q;
   logic [PTR_W-1:0]          wrcnt_q;
   logic [ADDR_W-1:0]         waddr_q;
   sync_fifo_pkg::wr_flags_t  flags_q;

   logic                      we_acc;
   logic [PTR_W-1:0]          wdiff;
   logic                      afull_set;
   logic                      afull_clr;
   logic                      afull_nxt;

   // write only goes through while registered full is low
   assign we_acc = we_i & ~flags_q.full;

   // occupancy after this cycle's accepted write
   // a read in the same cycle is not counted here
   assign wdiff = wptr_q + PTR_W'(we_acc) - rptr_i;

   // --------------------------------------------------
   // almost full hysteresis
   // --------------------------------------------------

   // set needs a live write request, set wins over clear
   assign afull_set = we_i & (wdiff >= AF_THR);
   assign afull_clr = (wdiff <= AF_THR);

   always_comb begin
      if (afull_set) begin
         afull_nxt = 1'b1;
      end else if (afull_clr) begin
         afull_nxt = 1'b0;
      end else begin
         // between the two thresholds, hold
         afull_nxt = flags_q.afull;
      end
   end

   // --------------------------------------------------
   // pointer and memory write address
   // --------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wptr_q  <= '0;
         waddr_q <= '0;
      end else if (we_acc) begin
         wptr_q <= wptr_q + PTR_W'(1);
         // wrap at the last entry
         if (waddr_q == LAST_ADDR) begin
            waddr_q <= '0;
         end else begin
            waddr_q <= waddr_q + ADDR_W'(1);
         end
      end
   end

   // --------------------------------------------------
   // status flags and count
   // --------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         flags_q <= '0;
         wrcnt_q <= '0;
      end else begin
         flags_q.full     <= (wdiff >= FULL_THR);
         flags_q.afull    <= afull_nxt;
         // one cycle pulses
         flags_q.wack     <= we_acc;
         flags_q.overflow <= we_i & flags_q.full;
         wrcnt_q          <= wdiff;
      end
   end

   // outputs
   assign wptr_o     = wptr_q;
   assign wr_flags_o = flags_q;
   assign wrcnt_o    = wrcnt_q;
   assign memwaddr_o = waddr_q;
   // enable is combinational, alongside the registered address
   assign memwe_o    = we_acc;

endmodule

`default_nettype wire

// File: hdl/fifo_read_port.sv
// read side of the FIFO controller: read pointer, memory read address and empty status
`default_nettype none
`timescale 1ns/1ps

module fifo_read_port #(
   parameter int ADDR_W       = sync_fifo_pkg::DEF_ADDR_W,
   parameter int AEMPTY_LEVEL = sync_fifo_pkg::DEF_AEMPTY_LEVEL
) (
   input  wire                       pos_clk,
   input  wire                       aresetn,
   input  wire                       re_i,
   input  wire  [ADDR_W:0]           wptr_i,
   output logic [ADDR_W:0]           rptr_o,
   output sync_fifo_pkg::rd_flags_t  rd_flags_o,
   output logic [ADDR_W:0]           rdcnt_o,
   output logic [ADDR_W-1:0]         memraddr_o,
   output logic                      memre_o
);

   // --------------------------------------------------
   // constants
   // --------------------------------------------------

   // pointer carries one extra wrap bit
   localparam int PTR_W = ADDR_W + 1;
   localparam int DEPTH = 2 ** ADDR_W;

   // almost empty compares at the level itself
   localparam logic [PTR_W-1:0] AE_THR = PTR_W'(AEMPTY_LEVEL);
   // last memory address before wrap
   localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

   // --------------------------------------------------
   // state and next-state signals
   // --------------------------------------------------
   logic [PTR_W-1:0]          rptr_q;
   logic [PTR_W-1:0]          rdcnt_q;
   logic [ADDR_W-1:0]         raddr_q;
   sync_fifo_pkg::rd_flags_t  flags_q;

   logic                      re_acc;
   logic [PTR_W-1:0]          rdiff;
   logic                      aempty_set;
   logic                      aempty_clr;
   logic                      aempty_nxt;

   // read only goes through while registered empty is low
   assign re_acc = re_i & ~flags_q.empty;

   // occupancy after this cycle's accepted read
   // a write in the same cycle is not counted here
   assign rdiff = wptr_i - rptr_q - PTR_W'(re_acc);

   // --------------------------------------------------
   // almost empty hysteresis
   // --------------------------------------------------

   // clear only from the set state, clear wins over set
   assign aempty_clr = flags_q.aempty & (rdiff >= AE_THR);
   assign aempty_set = re_i & (rdiff <= AE_THR);

   always_comb begin
      if (aempty_clr) begin
         aempty_nxt = 1'b0;
      end else if (aempty_set) begin
         aempty_nxt = 1'b1;
      end else begin
         // no trigger, hold
         aempty_nxt = flags_q.aempty;
      end
   end

   // --------------------------------------------------
   // pointer and memory read address
   // --------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rptr_q  <= '0;
         raddr_q <= '0;
      end else if (re_acc) begin
         rptr_q <= rptr_q + PTR_W'(1);
         // wrap at the last entry
         if (raddr_q == LAST_ADDR) begin
            raddr_q <= '0;
         end else begin
            raddr_q <= raddr_q + ADDR_W'(1);
         end
      end
   end

   // --------------------------------------------------
   // status flags and count
   // --------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         // starts empty and almost empty
         flags_q.empty     <= 1'b1;
         flags_q.aempty    <= 1'b1;
         flags_q.dvld      <= 1'b0;
         flags_q.underflow <= 1'b0;
         rdcnt_q           <= '0;
      end else begin
         flags_q.empty     <= (rdiff == '0);
         flags_q.aempty    <= aempty_nxt;
         // one cycle pulses
         flags_q.dvld      <= re_acc;
         flags_q.underflow <= re_i & flags_q.empty;
         rdcnt_q           <= rdiff;
      end
   end

   // outputs
   assign rptr_o     = rptr_q;
   assign rd_flags_o = flags_q;
   assign rdcnt_o    = rdcnt_q;
   assign memraddr_o = raddr_q;
   // enable is combinational, alongside the registered address
   assign memre_o    = re_acc;

endmodule

`default_nettype wire

// File: hdl/sync_fifo_ctrl.sv
// top level of the synchronous FIFO controller; drives an external memory, instantiate this
`default_nettype none
`timescale 1ns/1ps

module sync_fifo_ctrl #(
   parameter int ADDR_W       = sync_fifo_pkg::DEF_ADDR_W,
   parameter int AFULL_LEVEL  = sync_fifo_pkg::DEF_AFULL_LEVEL,
   parameter int AEMPTY_LEVEL = sync_fifo_pkg::DEF_AEMPTY_LEVEL
) (
   input  wire                       pos_clk,
   input  wire                       aresetn,
   input  wire                       we_i,
   input  wire                       re_i,
   // bundled status
   output sync_fifo_pkg::wr_flags_t  wr_flags_o,
   output sync_fifo_pkg::rd_flags_t  rd_flags_o,
   // same status as single pins
   output logic                      full_o,
   output logic                      afull_o,
   output logic                      wack_o,
   output logic                      overflow_o,
   output logic                      empty_o,
   output logic                      aempty_o,
   output logic                      dvld_o,
   output logic                      underflow_o,
   // occupancy counts
   output logic [ADDR_W:0]           wrcnt_o,
   output logic [ADDR_W:0]           rdcnt_o,
   // external memory side
   output logic [ADDR_W-1:0]         memwaddr_o,
   output logic                      memwe_o,
   output logic [ADDR_W-1:0]         memraddr_o,
   output logic                      memre_o
);

   // pointers crossing between the two ports
   logic [ADDR_W:0] wptr;
   logic [ADDR_W:0] rptr;

   // --------------------------------------------------
   // port instances
   // --------------------------------------------------
   fifo_write_port #(
      .ADDR_W      (ADDR_W),
      .AFULL_LEVEL (AFULL_LEVEL)
   ) i_fifo_write_port (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .we_i       (we_i),
      .rptr_i     (rptr),
      .wptr_o     (wptr),
      .wr_flags_o (wr_flags_o),
      .wrcnt_o    (wrcnt_o),
      .memwaddr_o (memwaddr_o),
      .memwe_o    (memwe_o)
   );

   fifo_read_port #(
      .ADDR_W       (ADDR_W),
      .AEMPTY_LEVEL (AEMPTY_LEVEL)
   ) i_fifo_read_port (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .re_i       (re_i),
      .wptr_i     (wptr),
      .rptr_o     (rptr),
      .rd_flags_o (rd_flags_o),
      .rdcnt_o    (rdcnt_o),
      .memraddr_o (memraddr_o),
      .memre_o    (memre_o)
   );

   // --------------------------------------------------
   // unpack flag bundles to pins
   // --------------------------------------------------
   assign full_o      = wr_flags_o.full;
   assign afull_o     = wr_flags_o.afull;
   assign wack_o      = wr_flags_o.wack;
   assign overflow_o  = wr_flags_o.overflow;
   assign empty_o     = rd_flags_o.empty;
   assign aempty_o    = rd_flags_o.aempty;
   assign dvld_o      = rd_flags_o.dvld;
   assign underflow_o = rd_flags_o.underflow;

endmodule

`default_nettype wire

// File: bench/fifo_properties.sv
// concurrent checks on the FIFO controller, bound into every sync_fifo_ctrl instance
`default_nettype none
`timescale 1ns/1ps

module fifo_properties (
   input wire pos_clk,
   input wire aresetn,
   input wire memwe_i,
   input wire memre_i,
   input wire full_i,
   input wire empty_i,
   input wire wack_i
);

   // failures so far, read back by the testbench top
   int fail_cnt = 0;

   // write enable only while room is left
   assert property (@(posedge pos_clk) disable iff (!aresetn) memwe_i |-> !full_i)
   else begin
      $error("memory write enable while full");
      fail_cnt++;
   end

   // read enable only while data is stored
   assert property (@(posedge pos_clk) disable iff (!aresetn) memre_i |-> !empty_i)
   else begin
      $error("memory read enable while empty");
      fail_cnt++;
   end

   // acknowledge is the write enable delayed by one clock
   assert property (@(posedge pos_clk) disable iff (!aresetn) wack_i == $past(memwe_i))
   else begin
      $error("write acknowledge does not follow write enable");
      fail_cnt++;
   end

   assert property (@(posedge pos_clk) disable iff (!aresetn) !(full_i && empty_i))
   else begin
      $error("full and empty set together");
      fail_cnt++;
   end

endmodule

bind sync_fifo_ctrl fifo_properties i_fifo_properties (
   .pos_clk (pos_clk),
   .aresetn (aresetn),
   .memwe_i (memwe_o),
   .memre_i (memre_o),
   .full_i  (full_o),
   .empty_i (empty_o),
   .wack_i  (wack_o)
);

`default_nettype wire

// File: bench/fifo_checker.sv
// reference model of the FIFO controller; watches the DUT pins and counts mismatches
`default_nettype none
`timescale 1ns/1ps

module fifo_checker #(
   parameter int ADDR_W       = sync_fifo_pkg::DEF_ADDR_W,
   parameter int AFULL_LEVEL  = sync_fifo_pkg::DEF_AFULL_LEVEL,
   parameter int AEMPTY_LEVEL = sync_fifo_pkg::DEF_AEMPTY_LEVEL
) (
   input  wire                       pos_clk,
   input  wire                       aresetn,
   input  wire                       we_i,
   input  wire                       re_i,
   input  sync_fifo_pkg::wr_flags_t  wr_flags_i,
   input  sync_fifo_pkg::rd_flags_t  rd_flags_i,
   // full afull wack overflow empty aempty dvld underflow
   input  wire  [7:0]                pins_i,
   input  wire  [ADDR_W:0]           wrcnt_i,
   input  wire  [ADDR_W:0]           rdcnt_i,
   input  wire  [ADDR_W-1:0]         memwaddr_i,
   input  wire                       memwe_i,
   input  wire  [ADDR_W-1:0]         memraddr_i,
   input  wire                       memre_i,
   output int                        err_cnt_o,
   // read wrap, underflow, write wrap, overflow, full
   output logic [4:0]                seen_o
);

   localparam int DEPTH = 2 ** ADDR_W;
   // model pointers carry a wrap bit too
   localparam int PMASK = 2 * DEPTH - 1;

   // --------------------------------------------------
   // model state after the last rising edge
   // --------------------------------------------------
   sync_fifo_pkg::wr_flags_t e_wr;
   sync_fifo_pkg::rd_flags_t e_rd;
   int wp;
   int rp;
   int e_wrcnt;
   int e_rdcnt;
   int e_waddr;
   int e_raddr;
   int err_cnt = 0;
   logic [4:0] seen = '0;

   assign err_cnt_o = err_cnt;
   assign seen_o    = seen;

   task automatic compare(input string name, input int exp_v, input int act_v);
      if (exp_v != act_v) begin
         $display("[ERROR] %0d ns %s expected 'h%0h actual 'h%0h", $time, name, exp_v, act_v);
         err_cnt++;
      end
   endtask

   // sampled at the falling edge, well away from the stimulus
   always @(negedge pos_clk) begin : model
      logic wacc;
      logic racc;
      int occ;
      int wdiff;
      int rdiff;
      if (!aresetn) begin
         e_wr        = '0;
         e_rd        = '0;
         e_rd.empty  = 1'b1;
         e_rd.aempty = 1'b1;
         wp      = 0;
         rp      = 0;
         e_wrcnt = 0;
         e_rdcnt = 0;
         e_waddr = 0;
         e_raddr = 0;
      end
      wacc = we_i & ~e_wr.full;
      racc = re_i & ~e_rd.empty;
      compare("wr_flags_o", int'(e_wr), int'(wr_flags_i));
      compare("rd_flags_o", int'(e_rd), int'(rd_flags_i));
      compare("single flag pins", int'({e_wr, e_rd}), int'(pins_i));
      compare("wrcnt_o", e_wrcnt, int'(wrcnt_i));
      compare("rdcnt_o", e_rdcnt, int'(rdcnt_i));
      // memory side follows the current requests
      compare("memwe_o", int'(wacc), int'(memwe_i));
      compare("memre_o", int'(racc), int'(memre_i));
      compare("memwaddr_o", e_waddr, int'(memwaddr_i));
      compare("memraddr_o", e_raddr, int'(memraddr_i));
      if (aresetn) begin
         seen = seen | {racc && (e_raddr == DEPTH - 1), e_rd.underflow,
                        wacc && (e_waddr == DEPTH - 1), e_wr.overflow, e_wr.full};
         occ   = (wp - rp) & PMASK;
         wdiff = occ + int'(wacc);
         rdiff = occ - int'(racc);
         // pulses see the old stops
         e_wr.overflow  = we_i & e_wr.full;
         e_rd.underflow = re_i & e_rd.empty;
         e_wr.wack      = wacc;
         e_rd.dvld      = racc;
         e_wr.full      = (wdiff >= DEPTH);
         e_rd.empty     = (rdiff == 0);
         // almost full, set wins
         if (we_i && wdiff >= AFULL_LEVEL - 1) begin
            e_wr.afull = 1'b1;
         end else if (wdiff <= AFULL_LEVEL - 1) begin
            e_wr.afull = 1'b0;
         end
         // almost empty, clear from set wins
         if (e_rd.aempty && rdiff >= AEMPTY_LEVEL) begin
            e_rd.aempty = 1'b0;
         end else if (re_i && rdiff <= AEMPTY_LEVEL) begin
            e_rd.aempty = 1'b1;
         end
         e_wrcnt = wdiff;
         e_rdcnt = rdiff;
         if (wacc) begin
            wp      = (wp + 1) & PMASK;
            e_waddr = (e_waddr == DEPTH - 1) ? 0 : e_waddr + 1;
         end
         if (racc) begin
            rp      = (rp + 1) & PMASK;
            e_raddr = (e_raddr == DEPTH - 1) ? 0 : e_raddr + 1;
         end
      end
   end

endmodule

`default_nettype wire

// File: bench/tb_sync_fifo_ctrl.sv
// testbench top: clock, reset, phased random requests, watchdog and the final verdict
`default_nettype none
`timescale 1ns/1ps

module tb_sync_fifo_ctrl;

   localparam int ADDR_W       = sync_fifo_pkg::DEF_ADDR_W;
   localparam int AFULL_LEVEL  = sync_fifo_pkg::DEF_AFULL_LEVEL;
   localparam int AEMPTY_LEVEL = sync_fifo_pkg::DEF_AEMPTY_LEVEL;
   localparam int HALF_PERIOD  = 20;
   localparam int PHASE_LEN    = 300;
   localparam int NUM_PHASES   = 4;
   // all phases plus reset, tail and slack
   localparam int TIMEOUT_NS   = (NUM_PHASES * PHASE_LEN + 40) * 2 * HALF_PERIOD;

   logic                     pos_clk;
   logic                     aresetn;
   logic                     we;
   logic                     re;
   logic [31:0]              rng;
   sync_fifo_pkg::wr_flags_t wr_flags;
   sync_fifo_pkg::rd_flags_t rd_flags;
   // single pins in bundle order
   logic [7:0]               pins;
   logic [ADDR_W:0]          wrcnt;
   logic [ADDR_W:0]          rdcnt;
   logic [ADDR_W-1:0]        memwaddr;
   logic [ADDR_W-1:0]        memraddr;
   logic                     memwe;
   logic                     memre;
   int                       err_cnt;
   logic [4:0]               seen;

   sync_fifo_ctrl #(
      .ADDR_W       (ADDR_W),
      .AFULL_LEVEL  (AFULL_LEVEL),
      .AEMPTY_LEVEL (AEMPTY_LEVEL)
   ) i_sync_fifo_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we),
      .re_i        (re),
      .wr_flags_o  (wr_flags),
      .rd_flags_o  (rd_flags),
      .full_o      (pins[7]),
      .afull_o     (pins[6]),
      .wack_o      (pins[5]),
      .overflow_o  (pins[4]),
      .empty_o     (pins[3]),
      .aempty_o    (pins[2]),
      .dvld_o      (pins[1]),
      .underflow_o (pins[0]),
      .wrcnt_o     (wrcnt),
      .rdcnt_o     (rdcnt),
      .memwaddr_o  (memwaddr),
      .memwe_o     (memwe),
      .memraddr_o  (memraddr),
      .memre_o     (memre)
   );

   fifo_checker #(
      .ADDR_W       (ADDR_W),
      .AFULL_LEVEL  (AFULL_LEVEL),
      .AEMPTY_LEVEL (AEMPTY_LEVEL)
   ) i_fifo_checker (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .we_i       (we),
      .re_i       (re),
      .wr_flags_i (wr_flags),
      .rd_flags_i (rd_flags),
      .pins_i     (pins),
      .wrcnt_i    (wrcnt),
      .rdcnt_i    (rdcnt),
      .memwaddr_i (memwaddr),
      .memwe_i    (memwe),
      .memraddr_i (memraddr),
      .memre_i    (memre),
      .err_cnt_o  (err_cnt),
      .seen_o     (seen)
   );

   // --------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // request probabilities are threshold/256
   task automatic run_phase(input int n, input logic [7:0] wr_thr, input logic [7:0] rd_thr);
      for (int i = 0; i < n; i++) begin
         @(posedge pos_clk);
         rng = xorshift32(rng);
         we <= (rng[7:0] < wr_thr);
         re <= (rng[15:8] < rd_thr);
      end
   endtask

   initial begin : clock_gen
      pos_clk = 1'b0;
      forever #(HALF_PERIOD) pos_clk = ~pos_clk;
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin : stimulus
      int miss_cnt;
      int total;
      rng     = 32'hc805;
      aresetn = 1'b0;
      we      = 1'b0;
      re      = 1'b0;
      repeat (3) @(posedge pos_clk);
      aresetn <= 1'b1;
      // fill, balanced, drain
      run_phase(PHASE_LEN, 8'd192, 8'd64);
      run_phase(PHASE_LEN, 8'd128, 8'd128);
      run_phase(PHASE_LEN, 8'd48, 8'd208);
      // fully random, fresh biases every 20 cycles
      for (int k = 0; k < PHASE_LEN / 20; k++) begin
         rng = xorshift32(rng);
         run_phase(20, rng[7:0], rng[15:8]);
      end
      @(posedge pos_clk);
      we <= 1'b0;
      re <= 1'b0;
      repeat (3) @(posedge pos_clk);
      miss_cnt = 5 - $countones(seen);
      if (miss_cnt != 0) begin
         $display("not every fill and drain case was reached, seen mask %b", seen);
      end
      total = err_cnt + i_sync_fifo_ctrl.i_fifo_properties.fail_cnt + miss_cnt;
      $display("errors: %0d mismatches, %0d assertion failures, %0d unreached cases",
               err_cnt, i_sync_fifo_ctrl.i_fifo_properties.fail_cnt, miss_cnt);
      if (total == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sync_fifo_ctrl.f
hdl/sync_fifo_pkg.sv
hdl/fifo_write_port.sv
hdl/fifo_read_port.sv
hdl/sync_fifo_ctrl.sv
bench/fifo_properties.sv
bench/fifo_checker.sv
bench/tb_sync_fifo_ctrl.sv

// File: Makefile
TOP := tb_sync_fifo_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sync_fifo_ctrl.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
